//--- list.f
common/blur_pkg.sv
common/ctrl_pkg.sv
kernel/line_buffer.sv
kernel/blur_3x3.sv
verilog/strip_merge.sv
verilog/blur_ctrl.sv
verilog/blur_top.sv
test/tb_clock.sv
test/blur_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the blur testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module blur_tb -f list.f -o blur_sim
	@out=$$(./obj_dir/blur_sim); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- test/blur_tb.sv
`timescale 1ns/1ps

module blur_tb;
  import blur_pkg::*;

  localparam int done_timeout = 2000;
  localparam int reset_timeout = 20;

  logic      clk;
  logic      rst_n;
  logic      start;
  logic      done;
  row_addr_t img_addr;
  logic      img_re;
  row_t      img_dout;
  row_addr_t res_addr;
  logic      res_we;
  row_t      res_din;
  row_t      res_dout;

  row_t      img_mem [img_rows];
  row_t      res_mem [img_rows];
  logic      img_rd;
  row_addr_t img_rd_addr;
  row_addr_t res_rd_addr;
  int        wr_count [img_rows];
  row_addr_t wr_addrs [$];
  int        done_cnt;
  logic [31:0] lfsr;
  int        checks;
  int        errors;
  int        tests_run;
  int        err_mark;

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));

  blur_top dut (
    .clk(clk), .rst_n(rst_n), .start(start), .done(done),
    .img_addr(img_addr), .img_re(img_re), .img_dout(img_dout),
    .res_addr(res_addr), .res_we(res_we), .res_din(res_din), .res_dout(res_dout)
  );

  // image memory with data one cycle after img_re
  always @(posedge clk) begin
    img_rd = img_re;
    img_rd_addr = img_addr;
    #1;
    if (img_rd) img_dout = img_mem[img_rd_addr];
  end

  // result memory writes at the edge and reads one cycle after the address
  always @(posedge clk) begin
    res_rd_addr = res_addr;
    if (rst_n && res_we) begin
      res_mem[res_addr] = res_din;
      wr_count[res_addr]++;
      wr_addrs.push_back(res_addr);
    end
    #1;
    res_dout = res_mem[res_rd_addr];
  end

  always @(posedge clk) begin
    if (rst_n && done) done_cnt++;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic pixel_t rand_pixel();
    pixel_t p;
    p = '0;
    for (int i = 0; i < pixel_bits; i++) begin
      lfsr = lfsr_next(lfsr);
      p = {p[pixel_bits-2:0], lfsr[0]};
    end
    return p;
  endfunction

  function automatic pixel_t img_pixel(input int r, input int c);
    if (r < 0 || r >= img_rows || c < 0 || c >= img_cols) return '0;
    return img_mem[r][c*pixel_bits +: pixel_bits];
  endfunction

  function automatic pixel_t res_pixel(input int r, input int c);
    return res_mem[r][c*pixel_bits +: pixel_bits];
  endfunction

  // weights 1-2-1 / 2-4-2 / 1-2-1 with zero outside and the sum / 16 truncated
  function automatic pixel_t ref_pixel(input int r, input int c);
    int sum;
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        sum += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * int'(img_pixel(r + dr, c + dc));
      end
    end
    return pixel_t'(sum / 16);
  endfunction

  task automatic check_pixel(input pixel_t got, input pixel_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_addr(input row_addr_t got, input row_addr_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string msg);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic fill_image(input int mode, input pixel_t value);
    for (int r = 0; r < img_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        // mode 0 is flat, 1 random and 2 all zero
        img_mem[r][c*pixel_bits +: pixel_bits] = (mode == 0) ? value :
                                                  (mode == 1) ? rand_pixel() : '0;
      end
    end
  endtask

  task automatic run_blur(input bit clear_res);
    int cycles;
    if (clear_res) begin
      for (int r = 0; r < img_rows; r++) res_mem[r] = '0;
    end
    for (int r = 0; r < img_rows; r++) wr_count[r] = 0;
    wr_addrs.delete();
    done_cnt = 0;
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    cycles = 0;
    while (!done) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > done_timeout) begin
        $display("timeout: done was not seen within %0d cycles", done_timeout);
        $display("STATUS: FAIL");
        $finish;
      end
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic compare_all(input string tag);
    for (int r = 0; r < img_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        check_pixel(res_pixel(r, c), ref_pixel(r, c),
                    $sformatf("%s row %0d col %0d", tag, r, c));
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) $display("%-16s ok", name);
    else $display("%-16s %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic test_reset_idle();
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      check_flag(done, 1'b0, "done while idle");
      check_flag(res_we, 1'b0, "res_we while idle");
    end
    end_test("reset_idle");
  endtask

  task automatic test_flat_image();
    bit r_edge;
    bit c_edge;
    fill_image(0, 8'd160);
    run_blur(1'b1);
    for (int r = 0; r < img_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        r_edge = (r == 0) || (r == img_rows - 1);
        c_edge = (c == 0) || (c == img_cols - 1);
        check_pixel(res_pixel(r, c), (r_edge && c_edge) ? 8'd90 :
                    (r_edge || c_edge) ? 8'd120 : 8'd160,
                    $sformatf("flat row %0d col %0d", r, c));
      end
    end
    end_test("flat_image");
  endtask

  task automatic test_random_image();
    fill_image(1, '0);
    run_blur(1'b1);
    compare_all("random");
    end_test("random_image");
  endtask

  // bright pixel in the last column of strip 1
  task automatic test_strip_boundary();
    fill_image(2, '0);
    img_mem[5][7*pixel_bits +: pixel_bits] = 8'd255;
    run_blur(1'b1);
    compare_all("boundary");
    check_pixel(res_pixel(5, 7), 8'd63, "centre in strip 1");
    check_pixel(res_pixel(5, 8), 8'd31, "halo into strip 2");
    check_pixel(res_pixel(4, 8), 8'd15, "diagonal into strip 2");
    end_test("strip_boundary");
  endtask

  task automatic test_write_pattern();
    fill_image(1, '0);
    run_blur(1'b1);
    for (int r = 0; r < img_rows; r++) begin
      check_count(wr_count[r], num_strips, $sformatf("writes to row %0d", r));
    end
    check_count(wr_addrs.size(), num_strips * img_rows, "total writes");
    foreach (wr_addrs[i]) begin
      check_addr(wr_addrs[i], row_addr_t'(i % img_rows), $sformatf("write %0d address", i));
    end
    check_count(done_cnt, 1, "done pulses");
    end_test("write_pattern");
  endtask

  // earlier result stays in memory and must be overwritten
  task automatic test_restart();
    fill_image(1, '0);
    run_blur(1'b0);
    compare_all("restart");
    check_count(done_cnt, 1, "done pulses on restart");
    end_test("restart");
  endtask

  initial begin
    int wait_cycles;
    start = 1'b0;
    img_dout = '0;
    res_dout = '0;
    lfsr = 32'hfab8eee9;
    checks = 0;
    errors = 0;
    tests_run = 0;
    err_mark = 0;
    done_cnt = 0;
    for (int r = 0; r < img_rows; r++) begin
      img_mem[r] = '0;
      res_mem[r] = '0;
      wr_count[r] = 0;
    end
    wait_cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > reset_timeout) begin
        $display("reset was never released");
        $display("STATUS: FAIL");
        $finish;
      end
    end
    test_reset_idle();
    test_flat_image();
    test_random_image();
    test_strip_boundary();
    test_write_pattern();
    test_restart();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset held for three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- verilog/blur_top.sv
`timescale 1ns/1ps

module blur_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  output logic                 done,
  output blur_pkg::row_addr_t  img_addr,
  output logic                 img_re,
  input  blur_pkg::row_t       img_dout,
  output blur_pkg::row_addr_t  res_addr,
  output logic                 res_we,
  output blur_pkg::row_t       res_din,
  input  blur_pkg::row_t       res_dout
);
  import blur_pkg::*;

  logic       lb_shift;
  logic       lb_zero;
  logic       kern_start;
  logic       kern_valid;
  strip_idx_t strip_idx;
  window_t    window;
  strip_t     strip_out;

  blur_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .kern_valid (kern_valid),
    .done       (done),
    .img_addr   (img_addr),
    .img_re     (img_re),
    .res_addr   (res_addr),
    .res_we     (res_we),
    .lb_shift   (lb_shift),
    .lb_zero    (lb_zero),
    .kern_start (kern_start),
    .strip_idx  (strip_idx)
  );

  line_buffer u_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .lb_shift  (lb_shift),
    .lb_zero   (lb_zero),
    .img_dout  (img_dout),
    .strip_idx (strip_idx),
    .window    (window)
  );

  blur_3x3 u_kernel (
    .clk        (clk),
    .rst_n      (rst_n),
    .kern_start (kern_start),
    .window     (window),
    .kern_valid (kern_valid),
    .strip_out  (strip_out)
  );

  strip_merge u_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .kern_valid (kern_valid),
    .strip_idx  (strip_idx),
    .strip_out  (strip_out),
    .res_dout   (res_dout),
    .res_din    (res_din)
  );

endmodule

//--- verilog/blur_ctrl.sv
`timescale 1ns/1ps

module blur_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  kern_valid,
  output logic                  done,
  output blur_pkg::row_addr_t   img_addr,
  output logic                  img_re,
  output blur_pkg::row_addr_t   res_addr,
  output logic                  res_we,
  output logic                  lb_shift,
  output logic                  lb_zero,
  output logic                  kern_start,
  output blur_pkg::strip_idx_t  strip_idx
);
  import blur_pkg::*;
  import ctrl_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  // 0 on the first cycle of a state, 1 while it is held
  logic        phase;
  row_addr_t   row_cnt;
  strip_idx_t  strip_cnt;
  logic        last_row;
  logic        last_strip;

  assign last_row   = (row_cnt == row_addr_t'(img_rows - 1));
  assign last_strip = (strip_cnt == strip_idx_t'(num_strips - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
      phase <= 1'b0;
    end else begin
      state <= state_nxt;
      phase <= (state_nxt == state);
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle:     if (start) state_nxt = prime;
      prime:    if (phase) state_nxt = load_row;
      load_row: if (phase) state_nxt = blur;
      blur:     if (kern_valid) state_nxt = merge;
      merge: begin
        if (!last_row)
          state_nxt = load_row;
        else if (last_strip)
          state_nxt = finish;
        else
          state_nxt = prime;
      end
      finish:   state_nxt = idle;
      default:  state_nxt = idle;
    endcase
  end

  // row walks down a strip, strip steps after the bottom row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt   <= '0;
      strip_cnt <= '0;
    end else begin
      case (state)
        idle:  strip_cnt <= '0;
        prime: row_cnt <= '0;
        merge: begin
          if (last_row)
            strip_cnt <= strip_cnt + 1'b1;
          else
            row_cnt <= row_cnt + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // prime reads row 0, load_row reads the row below the output row
  assign img_addr = (state == prime) ? '0 : row_addr_t'(row_cnt + 1'b1);
  assign img_re   = !phase && ((state == prime) || (state == load_row && !last_row));

  // shift lands one cycle after the read, zero row first in prime
  assign lb_shift = (state == prime) || (state == load_row && phase);
  assign lb_zero  = (state == prime && !phase) || (state == load_row && phase && last_row);

  assign kern_start = (state == blur) && !phase;
  assign res_addr   = row_cnt;
  assign res_we     = (state == merge);
  assign strip_idx  = strip_cnt;
  assign done       = (state == finish);

endmodule

//--- verilog/strip_merge.sv
`timescale 1ns/1ps

module strip_merge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  kern_valid,
  input  blur_pkg::strip_idx_t  strip_idx,
  input  blur_pkg::strip_t      strip_out,
  input  blur_pkg::row_t        res_dout,
  output blur_pkg::row_t        res_din
);
  import blur_pkg::*;

  row_t merged;

  // stored row with the current strip slice overwritten
  // strip 0 sits in the lowest pixels
  always_comb begin
    merged = res_dout;
    merged[strip_idx*strip_pixels*pixel_bits +: strip_pixels*pixel_bits] = strip_out;
  end

  // res_din is ready the cycle before the write strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_din <= '0;
    end else if (kern_valid) begin
      res_din <= merged;
    end
  end

endmodule

//--- kernel/blur_3x3.sv
`timescale 1ns/1ps

module blur_3x3 (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               kern_start,
  input  blur_pkg::window_t  window,
  output logic               kern_valid,
  output blur_pkg::strip_t   strip_out
);
  import blur_pkg::*;

  pixel_t                pix [3][strip_pixels+2];
  // 1-2-1 horizontal sums, max 4 * 255
  logic [pixel_bits+1:0] row_sum_d [3][strip_pixels];
  logic [pixel_bits+1:0] row_sum_q [3][strip_pixels];
  // 1-2-1 over the row sums, max 16 * 255
  logic [pixel_bits+3:0] tot_sum [strip_pixels];
  logic                  s1_valid;

  // unpack window and form the weighted row sums
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < strip_pixels + 2; j++) begin
        pix[k][j] = window[(k*(strip_pixels+2)+j)*pixel_bits +: pixel_bits];
      end
      for (int i = 0; i < strip_pixels; i++) begin
        row_sum_d[k][i] = {2'b00, pix[k][i]} + {1'b0, pix[k][i+1], 1'b0} +
                          {2'b00, pix[k][i+2]};
      end
    end
  end

  // stage one
  always_ff @(posedge clk) begin
    if (kern_start) begin
      row_sum_q <= row_sum_d;
    end
  end

  always_comb begin
    for (int i = 0; i < strip_pixels; i++) begin
      tot_sum[i] = {2'b00, row_sum_q[0][i]} + {1'b0, row_sum_q[1][i], 1'b0} +
                   {2'b00, row_sum_q[2][i]};
    end
  end

  // stage two, divide by 16 by dropping the low nibble
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      for (int i = 0; i < strip_pixels; i++) begin
        strip_out[i*pixel_bits +: pixel_bits] <= tot_sum[i][pixel_bits+3:4];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      kern_valid <= 1'b0;
    end else begin
      s1_valid   <= kern_start;
      kern_valid <= s1_valid;
    end
  end

endmodule

//--- kernel/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  lb_shift,
  input  logic                  lb_zero,
  input  blur_pkg::row_t        img_dout,
  input  blur_pkg::strip_idx_t  strip_idx,
  output blur_pkg::window_t     window
);
  import blur_pkg::*;

  // rows[0] oldest (above), rows[1] centre, rows[2] newest (below)
  row_t [2:0] rows;

  // each row with one zero pixel on both ends
  logic [2:0][(img_cols+2)*pixel_bits-1:0] padded;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rows <= '0;
    end else if (lb_shift) begin
      rows[0] <= rows[1];
      rows[1] <= rows[2];
      // zero row below the last image row
      rows[2] <= lb_zero ? '0 : img_dout;
    end
  end

  // padded pixel index is column + 1, so the strip window starts at strip_idx * 4
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      padded[k] = {pixel_t'(0), rows[k], pixel_t'(0)};
      window[k*(strip_pixels+2)*pixel_bits +: (strip_pixels+2)*pixel_bits] =
          padded[k][strip_idx*strip_pixels*pixel_bits +: (strip_pixels+2)*pixel_bits];
    end
  end

endmodule

//--- common/ctrl_pkg.sv
package ctrl_pkg;

  // blur controller states
  typedef enum logic [2:0] {
    // waiting for start
    idle,
    // zero row and image row 0 into the line buffer
    prime,
    // fetch next image row, or shift in a zero row below the image
    load_row,
    // kernel running on the current window
    blur,
    // result row write-back
    merge,
    // done pulse
    finish
  } ctrl_state_t;

endpackage

//--- common/blur_pkg.sv
package blur_pkg;

  // image geometry
  localparam int pixel_bits   = 8;
  localparam int img_rows     = 16;
  localparam int img_cols     = 16;
  localparam int strip_pixels = 4;
  localparam int num_strips   = img_cols / strip_pixels;

  // one grayscale pixel
  typedef logic [pixel_bits-1:0] pixel_t;

  // full image or result row, pixel 0 in the low bits
  typedef logic [img_cols*pixel_bits-1:0] row_t;

  // one blurred strip
  typedef logic [strip_pixels*pixel_bits-1:0] strip_t;

  // three rows of strip plus one halo pixel per side, oldest row low
  typedef logic [3*(strip_pixels+2)*pixel_bits-1:0] window_t;

  // row address into image and result memories
  typedef logic [$clog2(img_rows)-1:0] row_addr_t;

  // strip index within a row
  typedef logic [$clog2(num_strips)-1:0] strip_idx_t;

endpackage
